// ==== common/rob_retire_config.svh ====
`ifndef ROB_RETIRE_CONFIG_SVH
`define ROB_RETIRE_CONFIG_SVH

// reorder buffer sizing
// slot count must stay a power of two, the pointers wrap modulo ROB_NUM
`define ROB_NUM 32

// slot index width, log2 of ROB_NUM
`define ROB_SEL 5

// architectural register index width
`define REG_SEL 5

// instruction and branch target address width
`define ADDR_LEN 32

// global history length for gshare
// also the width of the table index
`define GSH_BHR_LEN 10

// pattern history table entries, 2**GSH_BHR_LEN
`define PHT_NUM 1024

`endif

// ==== common/rob_retire_pkg.sv ====
`default_nettype none
`include "rob_retire_config.svh"

package rob_retire_pkg;

    // slot index into the reorder buffer
    typedef logic [`ROB_SEL-1:0] rob_idx_t;

    // architectural register index
    typedef logic [`REG_SEL-1:0] reg_idx_t;

    // instruction address
    typedef logic [`ADDR_LEN-1:0] addr_t;

    // global history snapshot taken at fetch
    typedef logic [`GSH_BHR_LEN-1:0] bhr_t;

    // one dispatched instruction
    typedef struct packed {
        logic     valid;
        addr_t    pc;
        logic     store;
        logic     dst_valid;
        reg_idx_t dst;
        logic     branch;
        bhr_t     bhr;
    } disp_req_t;

    // completion pulse from an alu, mul or ldst unit
    typedef struct packed {
        logic     valid;
        rob_idx_t idx;
    } fin_t;

    // completion pulse from the branch unit, with resolved outcome
    typedef struct packed {
        logic     valid;
        rob_idx_t idx;
        logic     taken;
        addr_t    target;
    } br_fin_t;

    // one retire lane toward the architectural register file
    typedef struct packed {
        logic     retired;
        logic     we;
        reg_idx_t dst;
    } retire_t;

    // retired branch, used to train the predictor
    typedef struct packed {
        logic  valid;
        addr_t pc;
        bhr_t  bhr;
        logic  taken;
        addr_t target;
    } br_retire_t;

endpackage

`default_nettype wire

// ==== rob/rob_alloc.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rob_retire_config.svh"

module rob_alloc (
    input  wire                            clk_i,
    input  wire                            reset_i,
    input  wire rob_retire_pkg::disp_req_t dp1_i,
    input  wire rob_retire_pkg::disp_req_t dp2_i,
    input  wire [1:0]                      comnum_i,
    output rob_retire_pkg::disp_req_t      alloc1_o,
    output rob_retire_pkg::disp_req_t      alloc2_o,
    output rob_retire_pkg::rob_idx_t       alloc1_idx_o,
    output rob_retire_pkg::rob_idx_t       alloc2_idx_o,
    output logic                           disp_ready_o
);

    // next free slot, oldest-to-youngest order
    rob_retire_pkg::rob_idx_t disp_ptr;

    // occupied slots, 0 to ROB_NUM inclusive so one extra bit
    logic [`ROB_SEL:0] occ;
    logic [`ROB_SEL:0] free_num;

    // accepted dispatches this cycle, 0 to 2
    logic [1:0] acc_num;

    // wide sums for the modulo wrap
    logic [`ROB_SEL:0] ptr_sum;
    logic [`ROB_SEL:0] ptr_plus1;

    assign free_num = (`ROB_SEL+1)'(`ROB_NUM) - occ;

    // need room for a full pair, even if only one is offered
    assign disp_ready_o = (free_num >= (`ROB_SEL+1)'(2));

    always_comb begin
        alloc1_o       = dp1_i;
        alloc1_o.valid = dp1_i.valid & disp_ready_o;
        alloc2_o       = dp2_i;
        // second lane only rides along with the first
        alloc2_o.valid = dp2_i.valid & dp1_i.valid & disp_ready_o;
    end

    assign acc_num = {1'b0, alloc1_o.valid} + {1'b0, alloc2_o.valid};

    // slots are consecutive from the dispatch pointer
    assign ptr_plus1    = {1'b0, disp_ptr} + (`ROB_SEL+1)'(1);
    assign alloc1_idx_o = disp_ptr;
    assign alloc2_idx_o = rob_retire_pkg::rob_idx_t'(ptr_plus1 % `ROB_NUM);

    assign ptr_sum = {1'b0, disp_ptr} + {{(`ROB_SEL-1){1'b0}}, acc_num};

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            disp_ptr <= '0;
            occ      <= '0;
        end else begin
            disp_ptr <= rob_retire_pkg::rob_idx_t'(ptr_sum % `ROB_NUM);
            // add what went in, drop what retired
            occ <= occ + {{(`ROB_SEL-1){1'b0}}, acc_num}
                       - {{(`ROB_SEL-1){1'b0}}, comnum_i};
        end
    end

    // buffer never overfills, ties ready level to the retire count
    assert property (@(posedge clk_i) disable iff (reset_i)
        occ <= (`ROB_SEL+1)'(`ROB_NUM))
        else $error("rob_alloc: occupancy above ROB_NUM");

    // retire can only drain slots that were handed out
    assert property (@(posedge clk_i) disable iff (reset_i)
        {{(`ROB_SEL-1){1'b0}}, comnum_i} <= occ)
        else $error("rob_alloc: retire count exceeds occupancy");

endmodule

`default_nettype wire

// ==== rob/rob.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rob_retire_config.svh"

module rob (
    input  wire                            clk_i,
    input  wire                            reset_i,
    input  wire rob_retire_pkg::disp_req_t alloc1_i,
    input  wire rob_retire_pkg::disp_req_t alloc2_i,
    input  wire rob_retire_pkg::rob_idx_t  alloc1_idx_i,
    input  wire rob_retire_pkg::rob_idx_t  alloc2_idx_i,
    input  wire rob_retire_pkg::fin_t      fin_alu1_i,
    input  wire rob_retire_pkg::fin_t      fin_alu2_i,
    input  wire rob_retire_pkg::fin_t      fin_mul_i,
    input  wire rob_retire_pkg::fin_t      fin_ldst_i,
    input  wire rob_retire_pkg::br_fin_t   fin_br_i,
    output rob_retire_pkg::retire_t        ret1_o,
    output rob_retire_pkg::retire_t        ret2_o,
    output logic [1:0]                     comnum_o,
    output logic                           store_commit_o,
    output rob_retire_pkg::br_retire_t     br_ret_o
);

    // per-slot control flags
    logic [`ROB_NUM-1:0] slot_valid;
    logic [`ROB_NUM-1:0] slot_fin;

    // per-slot payload, written at dispatch or branch finish
    logic [`ROB_NUM-1:0]      slot_store;
    logic [`ROB_NUM-1:0]      slot_dst_valid;
    logic [`ROB_NUM-1:0]      slot_branch;
    logic [`ROB_NUM-1:0]      slot_taken;
    rob_retire_pkg::addr_t    slot_pc     [`ROB_NUM];
    rob_retire_pkg::addr_t    slot_target [`ROB_NUM];
    rob_retire_pkg::reg_idx_t slot_dst    [`ROB_NUM];
    rob_retire_pkg::bhr_t     slot_bhr    [`ROB_NUM];

    // head of the buffer and the entry behind it
    rob_retire_pkg::rob_idx_t com_ptr1;
    rob_retire_pkg::rob_idx_t com_ptr2;
    logic [`ROB_SEL:0]        ptr2_sum;
    logic [`ROB_SEL:0]        ptr_adv_sum;

    logic commit1;
    logic commit2;
    logic br1;
    logic br2;
    rob_retire_pkg::rob_idx_t br_sel;

    // dispatch and finish ports gathered for looping
    rob_retire_pkg::disp_req_t [1:0] alloc_vec;
    rob_retire_pkg::rob_idx_t  [1:0] alloc_idx_vec;
    rob_retire_pkg::fin_t      [3:0] fin_vec;

    // protocol error flags, only watched by assertions
    logic fin_err;
    logic disp_err;

    assign alloc_vec     = {alloc2_i, alloc1_i};
    assign alloc_idx_vec = {alloc2_idx_i, alloc1_idx_i};
    assign fin_vec       = {fin_ldst_i, fin_mul_i, fin_alu2_i, fin_alu1_i};

    assign ptr2_sum = {1'b0, com_ptr1} + (`ROB_SEL+1)'(1);
    assign com_ptr2 = rob_retire_pkg::rob_idx_t'(ptr2_sum % `ROB_NUM);

    // oldest retires as soon as it is done
    assign commit1 = slot_valid[com_ptr1] & slot_fin[com_ptr1];
    // second lane needs the first, and no two branches in one cycle
    assign commit2 = commit1 & slot_valid[com_ptr2] & slot_fin[com_ptr2]
                   & ~(slot_branch[com_ptr1] & slot_branch[com_ptr2]);

    assign comnum_o = {1'b0, commit1} + {1'b0, commit2};

    assign store_commit_o = (commit1 & slot_store[com_ptr1])
                          | (commit2 & slot_store[com_ptr2]);

    // register write lanes, dst zeroed when idle
    always_comb begin
        ret1_o.retired = commit1;
        ret1_o.we      = commit1 & slot_dst_valid[com_ptr1];
        ret1_o.dst     = commit1 ? slot_dst[com_ptr1] : '0;
        ret2_o.retired = commit2;
        ret2_o.we      = commit2 & slot_dst_valid[com_ptr2];
        ret2_o.dst     = commit2 ? slot_dst[com_ptr2] : '0;
    end

    // at most one of these is set by the commit2 rule
    assign br1    = commit1 & slot_branch[com_ptr1];
    assign br2    = commit2 & slot_branch[com_ptr2];
    assign br_sel = br1 ? com_ptr1 : com_ptr2;

    always_comb begin
        br_ret_o.valid  = br1 | br2;
        br_ret_o.pc     = br_ret_o.valid ? slot_pc[br_sel] : '0;
        br_ret_o.bhr    = br_ret_o.valid ? slot_bhr[br_sel] : '0;
        br_ret_o.taken  = br_ret_o.valid & slot_taken[br_sel];
        br_ret_o.target = br_ret_o.valid ? slot_target[br_sel] : '0;
    end

    // head advance, true modulo over the slot count
    assign ptr_adv_sum = {1'b0, com_ptr1} + {{(`ROB_SEL-1){1'b0}}, comnum_o};

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            com_ptr1   <= '0;
            slot_valid <= '0;
            slot_fin   <= '0;
        end else begin
            com_ptr1 <= rob_retire_pkg::rob_idx_t'(ptr_adv_sum % `ROB_NUM);
            for (int k = 0; k < 4; k++) begin
                if (fin_vec[k].valid) begin
                    slot_fin[fin_vec[k].idx] <= 1'b1;
                end
            end
            if (fin_br_i.valid) begin
                slot_fin[fin_br_i.idx] <= 1'b1;
            end
            if (commit1) begin
                slot_valid[com_ptr1] <= 1'b0;
            end
            if (commit2) begin
                slot_valid[com_ptr2] <= 1'b0;
            end
            // new entries land in free slots, so no clash with retire
            for (int k = 0; k < 2; k++) begin
                if (alloc_vec[k].valid) begin
                    slot_valid[alloc_idx_vec[k]] <= 1'b1;
                    slot_fin[alloc_idx_vec[k]]   <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int k = 0; k < 2; k++) begin
            if (alloc_vec[k].valid) begin
                slot_pc[alloc_idx_vec[k]]        <= alloc_vec[k].pc;
                slot_store[alloc_idx_vec[k]]     <= alloc_vec[k].store;
                slot_dst_valid[alloc_idx_vec[k]] <= alloc_vec[k].dst_valid;
                slot_dst[alloc_idx_vec[k]]       <= alloc_vec[k].dst;
                slot_branch[alloc_idx_vec[k]]    <= alloc_vec[k].branch;
                slot_bhr[alloc_idx_vec[k]]       <= alloc_vec[k].bhr;
            end
        end
        // resolved outcome arrives with the finish pulse
        if (fin_br_i.valid) begin
            slot_taken[fin_br_i.idx]  <= fin_br_i.taken;
            slot_target[fin_br_i.idx] <= fin_br_i.target;
        end
    end

    always_comb begin
        fin_err = fin_br_i.valid
                & (~slot_valid[fin_br_i.idx] | slot_fin[fin_br_i.idx]);
        for (int k = 0; k < 4; k++) begin
            if (fin_vec[k].valid
                && (!slot_valid[fin_vec[k].idx] || slot_fin[fin_vec[k].idx])) begin
                fin_err = 1'b1;
            end
        end
        disp_err = 1'b0;
        for (int k = 0; k < 2; k++) begin
            if (alloc_vec[k].valid && slot_valid[alloc_idx_vec[k]]) begin
                disp_err = 1'b1;
            end
        end
    end

    // execution units only report slots that are live and still pending
    assert property (@(posedge clk_i) disable iff (reset_i) !fin_err)
        else $error("rob: finish report on idle or finished slot");

    // allocator must hand out free slots only
    assert property (@(posedge clk_i) disable iff (reset_i) !disp_err)
        else $error("rob: dispatch into an occupied slot");

endmodule

`default_nettype wire

// ==== src/gshare_pht.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rob_retire_config.svh"

module gshare_pht (
    input  wire                             clk_i,
    input  wire                             reset_i,
    input  wire rob_retire_pkg::br_retire_t br_ret_i,
    input  wire rob_retire_pkg::addr_t      pred_pc_i,
    input  wire rob_retire_pkg::bhr_t       pred_bhr_i,
    output logic                            pred_taken_o
);

    // two-bit saturating counters
    // 00 strong not-taken, 01 weak not-taken, 10 weak taken, 11 strong taken
    logic [1:0] pht [`PHT_NUM];

    logic [`GSH_BHR_LEN-1:0] train_idx;
    logic [`GSH_BHR_LEN-1:0] pred_idx;
    logic [1:0]              train_cnt;
    logic [1:0]              train_nxt;

    // word-aligned pc bits folded with history
    assign train_idx = br_ret_i.pc[`GSH_BHR_LEN+1:2] ^ br_ret_i.bhr;
    assign pred_idx  = pred_pc_i[`GSH_BHR_LEN+1:2] ^ pred_bhr_i;

    assign train_cnt = pht[train_idx];

    always_comb begin
        train_nxt = train_cnt;
        if (br_ret_i.taken) begin
            // count up, stop at strong taken
            if (train_cnt != 2'b11) begin
                train_nxt = train_cnt + 2'b01;
            end
        end else begin
            if (train_cnt != 2'b00) begin
                train_nxt = train_cnt - 2'b01;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `PHT_NUM; i++) begin
                pht[i] <= 2'b01;
            end
        end else if (br_ret_i.valid) begin
            pht[train_idx] <= train_nxt;
        end
    end

    // msb of the counter is the direction
    assign pred_taken_o = pht[pred_idx][1];

endmodule

`default_nettype wire

// ==== src/rob_retire_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_retire_top (
    input  wire                            clk_i,
    input  wire                            reset_i,
    input  wire rob_retire_pkg::disp_req_t dp1_i,
    input  wire rob_retire_pkg::disp_req_t dp2_i,
    output logic                           disp_ready_o,
    input  wire rob_retire_pkg::fin_t      fin_alu1_i,
    input  wire rob_retire_pkg::fin_t      fin_alu2_i,
    input  wire rob_retire_pkg::fin_t      fin_mul_i,
    input  wire rob_retire_pkg::fin_t      fin_ldst_i,
    input  wire rob_retire_pkg::br_fin_t   fin_br_i,
    output rob_retire_pkg::retire_t        ret1_o,
    output rob_retire_pkg::retire_t        ret2_o,
    output logic                           store_commit_o,
    output rob_retire_pkg::br_retire_t     br_ret_o,
    input  wire rob_retire_pkg::addr_t     pred_pc_i,
    input  wire rob_retire_pkg::bhr_t      pred_bhr_i,
    output logic                           pred_taken_o
);

    // gated dispatch with assigned slots
    rob_retire_pkg::disp_req_t alloc1;
    rob_retire_pkg::disp_req_t alloc2;
    rob_retire_pkg::rob_idx_t  alloc1_idx;
    rob_retire_pkg::rob_idx_t  alloc2_idx;

    // retire count back to the occupancy counter
    logic [1:0] comnum;

    rob_alloc rob_alloc_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .dp1_i        (dp1_i),
        .dp2_i        (dp2_i),
        .comnum_i     (comnum),
        .alloc1_o     (alloc1),
        .alloc2_o     (alloc2),
        .alloc1_idx_o (alloc1_idx),
        .alloc2_idx_o (alloc2_idx),
        .disp_ready_o (disp_ready_o)
    );

    rob rob_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .alloc1_i       (alloc1),
        .alloc2_i       (alloc2),
        .alloc1_idx_i   (alloc1_idx),
        .alloc2_idx_i   (alloc2_idx),
        .fin_alu1_i     (fin_alu1_i),
        .fin_alu2_i     (fin_alu2_i),
        .fin_mul_i      (fin_mul_i),
        .fin_ldst_i     (fin_ldst_i),
        .fin_br_i       (fin_br_i),
        .ret1_o         (ret1_o),
        .ret2_o         (ret2_o),
        .comnum_o       (comnum),
        .store_commit_o (store_commit_o),
        .br_ret_o       (br_ret_o)
    );

    // trained straight from the retired branch port
    gshare_pht gshare_pht_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .br_ret_i     (br_ret_o),
        .pred_pc_i    (pred_pc_i),
        .pred_bhr_i   (pred_bhr_i),
        .pred_taken_o (pred_taken_o)
    );

endmodule

`default_nettype wire

// ==== dv/tb_rob_retire.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rob_retire_config.svh"

module tb_rob_retire;

    localparam int NUM_INSTR      = 160;
    localparam int TIMEOUT_CYCLES = 4 * NUM_INSTR + 200;

    // one in-flight instruction as the model sees it
    typedef struct packed {
        rob_retire_pkg::rob_idx_t  slot;
        rob_retire_pkg::disp_req_t req;
        logic                      fin;
        logic                      taken;
        rob_retire_pkg::addr_t     target;
    } model_ent_t;

    logic                       clk_i;
    logic                       reset_i;
    rob_retire_pkg::disp_req_t  dp1_i;
    rob_retire_pkg::disp_req_t  dp2_i;
    logic                       disp_ready_o;
    rob_retire_pkg::fin_t       fin_alu1_i;
    rob_retire_pkg::fin_t       fin_alu2_i;
    rob_retire_pkg::fin_t       fin_mul_i;
    rob_retire_pkg::fin_t       fin_ldst_i;
    rob_retire_pkg::br_fin_t    fin_br_i;
    rob_retire_pkg::retire_t    ret1_o;
    rob_retire_pkg::retire_t    ret2_o;
    logic                       store_commit_o;
    rob_retire_pkg::br_retire_t br_ret_o;
    rob_retire_pkg::addr_t      pred_pc_i;
    rob_retire_pkg::bhr_t       pred_bhr_i;
    logic                       pred_taken_o;

    // program-order queue, head is the oldest
    model_ent_t model_q[$];
    logic [1:0] model_pht [`PHT_NUM];
    int         model_ptr = 0;
    int         disp_cnt = 0;
    int         retired_cnt = 0;
    int         cycle_cnt = 0;
    int         low_cycles = 0;
    logic       hold_fin = 1'b1;
    logic       saw_recover = 1'b0;
    logic       dual_seen = 1'b0;
    logic       br_pair_seen = 1'b0;
    logic       store_seen = 1'b0;
    rob_retire_pkg::addr_t last_br_pc = '0;
    rob_retire_pkg::bhr_t  last_br_bhr = '0;

    rob_retire_top rob_retire_top_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .dp1_i          (dp1_i),
        .dp2_i          (dp2_i),
        .disp_ready_o   (disp_ready_o),
        .fin_alu1_i     (fin_alu1_i),
        .fin_alu2_i     (fin_alu2_i),
        .fin_mul_i      (fin_mul_i),
        .fin_ldst_i     (fin_ldst_i),
        .fin_br_i       (fin_br_i),
        .ret1_o         (ret1_o),
        .ret2_o         (ret2_o),
        .store_commit_o (store_commit_o),
        .br_ret_o       (br_ret_o),
        .pred_pc_i      (pred_pc_i),
        .pred_bhr_i     (pred_bhr_i),
        .pred_taken_o   (pred_taken_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_retire(input string lane, input rob_retire_pkg::retire_t got,
                                input rob_retire_pkg::retire_t exp);
        // dst only matters on a retiring lane
        if (got.retired !== exp.retired || got.we !== exp.we
            || (exp.retired && got.dst !== exp.dst)) begin
            abort_run($sformatf("Error at %0t: %s retired=%0b we=%0b dst=%0d, exp %0b %0b %0d",
                      $time, lane, got.retired, got.we, got.dst,
                      exp.retired, exp.we, exp.dst));
        end
    endtask

    task automatic check_branch(input rob_retire_pkg::br_retire_t got,
                                input rob_retire_pkg::br_retire_t exp);
        if (got.valid !== exp.valid || (exp.valid && (got.pc !== exp.pc
            || got.bhr !== exp.bhr || got.taken !== exp.taken
            || got.target !== exp.target))) begin
            abort_run($sformatf("Error at %0t: br_ret_o %0b %h %h %0b %h, exp %0b %h %h %0b %h",
                      $time, got.valid, got.pc, got.bhr, got.taken, got.target,
                      exp.valid, exp.pc, exp.bhr, exp.taken, exp.target));
        end
    endtask

    task automatic check_pred(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t: pred_taken_o is %0b for pc %h bhr %h, expected %0b",
                      $time, got, pred_pc_i, pred_bhr_i, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t: %s is %0b, expected %0b", $time, name, got, exp));
        end
    endtask

    // gshare index, word pc bits folded with history
    function automatic int pht_index(input rob_retire_pkg::addr_t pc,
                                     input rob_retire_pkg::bhr_t bhr);
        logic [`GSH_BHR_LEN-1:0] idx;
        idx = pc[`GSH_BHR_LEN+1:2] ^ bhr;
        return int'(idx);
    endfunction

    // head retires when done, second only behind it and not as a second branch
    function automatic int exp_retire_num();
        int n;
        n = 0;
        if (model_q.size() > 0 && model_q[0].fin) begin
            n = 1;
            if (model_q.size() > 1 && model_q[1].fin
                && !(model_q[0].req.branch && model_q[1].req.branch)) begin
                n = 2;
            end
        end
        return n;
    endfunction

    function automatic rob_retire_pkg::retire_t exp_lane(input int n, input int lane);
        rob_retire_pkg::retire_t r;
        r = '0;
        if (lane < n) begin
            r.retired = 1'b1;
            r.we      = model_q[lane].req.dst_valid;
            r.dst     = model_q[lane].req.dst;
        end
        return r;
    endfunction

    function automatic logic exp_store(input int n);
        logic s;
        s = 1'b0;
        for (int i = 0; i < n; i++) begin
            s = s | model_q[i].req.store;
        end
        return s;
    endfunction

    // oldest retiring branch
    function automatic rob_retire_pkg::br_retire_t exp_branch(input int n);
        rob_retire_pkg::br_retire_t b;
        b = '0;
        for (int i = 0; i < n; i++) begin
            if (!b.valid && model_q[i].req.branch) begin
                b.valid  = 1'b1;
                b.pc     = model_q[i].req.pc;
                b.bhr    = model_q[i].req.bhr;
                b.taken  = model_q[i].taken;
                b.target = model_q[i].target;
            end
        end
        return b;
    endfunction

    task automatic mark_finished(input rob_retire_pkg::rob_idx_t slot, input logic taken,
                                 input rob_retire_pkg::addr_t target, input logic is_br);
        model_ent_t e;
        for (int i = 0; i < model_q.size(); i++) begin
            if (model_q[i].slot == slot) begin
                e = model_q[i];
                e.fin = 1'b1;
                if (is_br) begin
                    e.taken  = taken;
                    e.target = target;
                end
                model_q[i] = e;
            end
        end
    endtask

    task automatic push_entry(input rob_retire_pkg::disp_req_t req);
        model_ent_t e;
        e      = '0;
        e.slot = rob_retire_pkg::rob_idx_t'(model_ptr);
        e.req  = req;
        model_q.push_back(e);
        model_ptr = (model_ptr + 1) % `ROB_NUM;
    endtask

    task automatic make_instr(output rob_retire_pkg::disp_req_t r);
        r       = '0;
        r.valid = 1'b1;
        // few pcs and histories, so table entries get trained repeatedly
        r.pc        = rob_retire_pkg::addr_t'(32'h1000 + ($urandom % 8) * 4);
        r.bhr       = rob_retire_pkg::bhr_t'($urandom % 4);
        r.branch    = ($urandom % 5) < 2;
        r.store     = !r.branch && ($urandom % 4 == 0);
        r.dst_valid = !r.branch && !r.store && ($urandom % 4 != 0);
        r.dst       = rob_retire_pkg::reg_idx_t'($urandom);
    endtask

    // shuffled finish order over the pending entries
    task automatic drive_finishes();
        int                   nb[$];
        int                   bq[$];
        int                   pick;
        rob_retire_pkg::fin_t f [4];
        fin_br_i = '0;
        for (int i = 0; i < model_q.size(); i++) begin
            if (!model_q[i].fin && model_q[i].req.branch) begin
                bq.push_back(i);
            end else if (!model_q[i].fin) begin
                nb.push_back(i);
            end
        end
        for (int p = 0; p < 4; p++) begin
            f[p] = '0;
            if (!hold_fin && nb.size() > 0 && $urandom % 2 == 0) begin
                pick       = $urandom % nb.size();
                f[p].valid = 1'b1;
                f[p].idx   = model_q[nb[pick]].slot;
                nb.delete(pick);
            end
        end
        fin_alu1_i = f[0];
        fin_alu2_i = f[1];
        fin_mul_i  = f[2];
        fin_ldst_i = f[3];
        if (!hold_fin && bq.size() > 0 && $urandom % 2 == 0) begin
            pick            = $urandom % bq.size();
            fin_br_i.valid  = 1'b1;
            fin_br_i.idx    = model_q[bq[pick]].slot;
            fin_br_i.target = rob_retire_pkg::addr_t'($urandom);
            // pc bit 2 biases the direction, so counters move both ways
            if (model_q[bq[pick]].req.pc[2]) begin
                fin_br_i.taken = ($urandom % 8) != 0;
            end else begin
                fin_br_i.taken = ($urandom % 8) == 0;
            end
        end
    endtask

    // compare against the model, then advance it across this edge
    always @(posedge clk_i) begin : compare
        int                         n;
        int                         idx;
        logic                       ready_exp;
        rob_retire_pkg::br_retire_t br;
        if (!reset_i) begin
            n         = exp_retire_num();
            br        = exp_branch(n);
            ready_exp = (`ROB_NUM - model_q.size()) >= 2;
            check_flag("disp_ready_o", disp_ready_o, ready_exp);
            check_retire("ret1_o", ret1_o, exp_lane(n, 0));
            check_retire("ret2_o", ret2_o, exp_lane(n, 1));
            check_flag("store_commit_o", store_commit_o, exp_store(n));
            check_branch(br_ret_o, br);
            check_pred(pred_taken_o, model_pht[pht_index(pred_pc_i, pred_bhr_i)][1]);
            if (n == 2) begin
                dual_seen = 1'b1;
            end
            if (n == 1 && model_q.size() > 1 && model_q[1].fin) begin
                br_pair_seen = 1'b1;
            end
            if (exp_store(n)) begin
                store_seen = 1'b1;
            end
            // saturating two-bit training
            if (br.valid) begin
                idx = pht_index(br.pc, br.bhr);
                if (br.taken && model_pht[idx] != 2'd3) begin
                    model_pht[idx] = model_pht[idx] + 2'd1;
                end else if (!br.taken && model_pht[idx] != 2'd0) begin
                    model_pht[idx] = model_pht[idx] - 2'd1;
                end
                last_br_pc  = br.pc;
                last_br_bhr = br.bhr;
            end
            for (int i = 0; i < n; i++) begin
                model_q.delete(0);
            end
            retired_cnt = retired_cnt + n;
            if (fin_alu1_i.valid) begin
                mark_finished(fin_alu1_i.idx, 1'b0, '0, 1'b0);
            end
            if (fin_alu2_i.valid) begin
                mark_finished(fin_alu2_i.idx, 1'b0, '0, 1'b0);
            end
            if (fin_mul_i.valid) begin
                mark_finished(fin_mul_i.idx, 1'b0, '0, 1'b0);
            end
            if (fin_ldst_i.valid) begin
                mark_finished(fin_ldst_i.idx, 1'b0, '0, 1'b0);
            end
            if (fin_br_i.valid) begin
                mark_finished(fin_br_i.idx, fin_br_i.taken, fin_br_i.target, 1'b1);
            end
            if (dp1_i.valid && ready_exp) begin
                push_entry(dp1_i);
                if (dp2_i.valid) begin
                    push_entry(dp2_i);
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout: not all instructions retired within %0d cycles",
                      TIMEOUT_CYCLES));
        end
    end

    initial begin : stimulus
        rob_retire_pkg::disp_req_t r1;
        rob_retire_pkg::disp_req_t r2;
        void'($urandom(32'h65f3f19f));
        reset_i    = 1'b1;
        dp1_i      = '0;
        dp2_i      = '0;
        fin_alu1_i = '0;
        fin_alu2_i = '0;
        fin_mul_i  = '0;
        fin_ldst_i = '0;
        fin_br_i   = '0;
        pred_pc_i  = '0;
        pred_bhr_i = '0;
        for (int i = 0; i < `PHT_NUM; i++) begin
            model_pht[i] = 2'b01;
        end
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        while (retired_cnt < NUM_INSTR) begin
            @(negedge clk_i);
            dp1_i = '0;
            dp2_i = '0;
            // finishes held until the buffer has sat full for a few cycles
            if (hold_fin) begin
                if (!disp_ready_o) begin
                    low_cycles++;
                end
                if (low_cycles >= 4) begin
                    hold_fin = 1'b0;
                end
            end else if (low_cycles > 0 && disp_ready_o) begin
                saw_recover = 1'b1;
            end
            if (disp_ready_o && disp_cnt < NUM_INSTR && (hold_fin || $urandom % 4 != 0)) begin
                make_instr(r1);
                dp1_i    = r1;
                disp_cnt = disp_cnt + 1;
                if (disp_cnt < NUM_INSTR && (hold_fin || $urandom % 2 == 0)) begin
                    make_instr(r2);
                    dp2_i    = r2;
                    disp_cnt = disp_cnt + 1;
                end
            end
            drive_finishes();
            // look up the most recently trained branch
            pred_pc_i  = last_br_pc;
            pred_bhr_i = last_br_bhr;
        end
        @(negedge clk_i);
        @(negedge clk_i);
        if (model_q.size() == 0 && saw_recover && dual_seen && br_pair_seen && store_seen) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("run ended without covering back-pressure, dual, branch pair or store");
        end
    end

endmodule

`default_nettype wire

// ==== rob_retire.f ====
+incdir+common
common/rob_retire_pkg.sv
rob/rob_alloc.sv
rob/rob.sv
src/gshare_pht.sv
src/rob_retire_top.sv
dv/tb_rob_retire.sv

// ==== Makefile ====
SIM = obj_dir/sim_rob_retire

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --assert -f rob_retire.f --top-module tb_rob_retire -o sim_rob_retire
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir
